//--- include/fetch_macros.svh
// fetch macros: sizing constants shared by the instruction FIFO and the prefetch buffer

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

////////////////////////////////////////
// buffer sizing
////////////////////////////////////////

// number of words the prefetch FIFO can hold
`define FETCH_FIFO_DEPTH 4

// granted requests allowed in flight before a response comes back
`define FETCH_MAX_OUTSTANDING 2

////////////////////////////////////////
// derived widths
////////////////////////////////////////

`define FETCH_CNT_W 3 // holds 0..FETCH_FIFO_DEPTH plus in-flight sum
`define FETCH_PTR_W 2 // log2 of FETCH_FIFO_DEPTH, FIFO read/write pointers

`endif

//--- source/fetch_pkg.sv
// fetch package: address/instruction types and the selector and state encodings

package fetch_pkg;

  ////////////////////////////////////////
  // data types
  ////////////////////////////////////////

  typedef logic [31:0] addr_t;      // byte address
  typedef logic [31:0] instr_t;     // one instruction word
  typedef logic [23:0] trap_base_t; // upper bits of the trap vector base

  ////////////////////////////////////////
  // selectors
  ////////////////////////////////////////

  // next pc source, driven by the controller
  typedef enum logic [3:0] {
    PC_BOOT      = 4'b0000,
    PC_FENCEI    = 4'b0001, // refetch after the fence.i
    PC_JUMP      = 4'b0010, // jump resolved in decode
    PC_BRANCH    = 4'b0011, // branch resolved in execute
    PC_EXCEPTION = 4'b0100, // trap vector, see exc_pc_mux_e
    PC_MRET      = 4'b0101,
    PC_DRET      = 4'b0111
  } pc_mux_e;

  // which trap vector when pc_mux is PC_EXCEPTION
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'b00, // synchronous exception, base address
    EXC_PC_IRQ       = 2'b01, // vectored interrupt
    EXC_PC_DBD       = 2'b10  // debug halt entry
  } exc_pc_mux_e;

  ////////////////////////////////////////
  // state machines
  ////////////////////////////////////////

  typedef enum logic [0:0] {IDLE, WAIT} fetch_fsm_e; // if_stage request fsm
  typedef enum logic [0:0] {RUN, FLUSH} pf_fsm_e;    // stale response tracking

endpackage

//--- source/fetch_fifo.sv
// fetch_fifo: small circular instruction buffer with single-cycle flush

`timescale 1ns/10ps

`include "fetch_macros.svh"

module fetch_fifo (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,     // drop all entries
  input  logic                    push_i,
  input  fetch_pkg::instr_t       push_data_i,
  input  logic                    pop_i,
  output fetch_pkg::instr_t       pop_data_o,  // head of the queue
  output logic                    empty_o,
  output logic [`FETCH_CNT_W-1:0] count_o      // occupancy, used for credits
);

  fetch_pkg::instr_t mem [`FETCH_FIFO_DEPTH]; // storage, no reset

  logic [`FETCH_PTR_W-1:0] wr_ptr_q;
  logic [`FETCH_PTR_W-1:0] rd_ptr_q;
  logic [`FETCH_CNT_W-1:0] count_q;

  ////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // flush wins over a push or pop in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1; // depth is a power of two, wraps
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // none or both, level stays
      endcase
    end
  end

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  assign pop_data_o = mem[rd_ptr_q];      // valid only when not empty
  assign empty_o    = (count_q == '0);
  assign count_o    = count_q;

endmodule

//--- source/prefetch_buffer.sv
// prefetch_buffer: instruction bus master with credit-limited issue and stale-response drop

`timescale 1ns/10ps

`include "fetch_macros.svh"

module prefetch_buffer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_i,          // fetching enabled
  input  logic              branch_i,       // redirect to branch_addr_i
  input  fetch_pkg::addr_t  branch_addr_i,
  input  logic              fetch_ready_i,  // if_stage takes the head word
  output logic              fetch_valid_o,
  output fetch_pkg::instr_t fetch_rdata_o,
  output logic              instr_req_o,
  output fetch_pkg::addr_t  instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  fetch_pkg::instr_t instr_rdata_i,
  output logic              busy_o          // requests in flight or being driven
);

  localparam logic [`FETCH_CNT_W-1:0] depth_lim = `FETCH_CNT_W'(`FETCH_FIFO_DEPTH);
  localparam logic [`FETCH_CNT_W-1:0] max_out   = `FETCH_CNT_W'(`FETCH_MAX_OUTSTANDING);

  fetch_pkg::addr_t        addr_q;            // address of the next request
  fetch_pkg::pf_fsm_e      state_q, state_n;
  logic [`FETCH_CNT_W-1:0] outst_q, outst_n;  // granted, not yet answered
  logic [`FETCH_CNT_W-1:0] stale_q, stale_n;  // responses still to drop
  logic [`FETCH_CNT_W-1:0] fifo_count;
  logic [`FETCH_CNT_W-1:0] fill;              // slots used or promised
  logic                    fifo_empty;
  logic                    fifo_push;
  logic                    fifo_pop;
  logic                    credit_ok;
  logic                    req_gnt;

  ////////////////////////////////////////
  // request issue
  ////////////////////////////////////////

  // fifo is flushed during a branch, so its entries no longer count
  assign fill        = (branch_i ? '0 : fifo_count) + outst_q;
  assign credit_ok   = (fill < depth_lim) && (outst_q < max_out);
  assign instr_req_o = req_i & credit_ok;
  assign instr_addr_o = branch_i ? branch_addr_i : addr_q; // target goes out same cycle
  assign req_gnt     = instr_req_o & instr_gnt_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (branch_i) begin
      // skip ahead when the target itself was granted right away
      addr_q <= req_gnt ? branch_addr_i + 32'd4 : branch_addr_i;
    end else if (req_gnt) begin
      addr_q <= addr_q + 32'd4; // word stream
    end
  end

  ////////////////////////////////////////
  // outstanding and stale tracking
  ////////////////////////////////////////

  always_comb begin
    outst_n = outst_q;
    if (req_gnt) begin
      outst_n = outst_n + `FETCH_CNT_W'(1);
    end
    if (instr_rvalid_i) begin
      outst_n = outst_n - `FETCH_CNT_W'(1); // never underflows, bus answers only grants
    end
  end

  always_comb begin
    state_n = state_q;
    stale_n = stale_q;
    if (branch_i) begin
      // everything still in flight belongs to the old stream
      // a response in this very cycle is dropped here already
      stale_n = instr_rvalid_i ? outst_q - `FETCH_CNT_W'(1) : outst_q;
      state_n = (stale_n != '0) ? fetch_pkg::FLUSH : fetch_pkg::RUN;
    end else if ((state_q == fetch_pkg::FLUSH) && instr_rvalid_i) begin
      stale_n = stale_q - `FETCH_CNT_W'(1);
      if (stale_q == `FETCH_CNT_W'(1)) begin
        state_n = fetch_pkg::RUN; // last stale word gone
      end
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::RUN;
      outst_q <= '0;
      stale_q <= '0;
    end else begin
      state_q <= state_n;
      outst_q <= outst_n;
      stale_q <= stale_n;
    end
  end

  ////////////////////////////////////////
  // word buffer
  ////////////////////////////////////////

  // responses are in order, so in RUN every one belongs to the live stream
  assign fifo_push = instr_rvalid_i && (state_q == fetch_pkg::RUN) && !branch_i;
  assign fifo_pop  = fetch_ready_i & ~fifo_empty;

  fetch_fifo u_fetch_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (branch_i),
    .push_i      (fifo_push),
    .push_data_i (instr_rdata_i),
    .pop_i       (fifo_pop),
    .pop_data_o  (fetch_rdata_o),
    .empty_o     (fifo_empty),
    .count_o     (fifo_count)
  );

  assign fetch_valid_o = ~fifo_empty;
  assign busy_o        = (outst_q != '0) | instr_req_o;

endmodule

//--- source/fetch_pc_select.sv
// fetch_pc_select: next program counter mux with trap, interrupt and debug vector build

`timescale 1ns/10ps

module fetch_pc_select (
  input  fetch_pkg::pc_mux_e     pc_mux_i,          // redirect source
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,      // which vector for PC_EXCEPTION
  input  logic [30:0]            boot_addr_i,
  input  fetch_pkg::trap_base_t  trap_base_addr_i,  // mtvec upper bits
  input  logic [4:0]             irq_id_i,          // vectored interrupt number
  input  logic [29:0]            dm_halt_addr_i,    // debug module entry, word address
  input  fetch_pkg::addr_t       jump_target_id_i,  // from decode
  input  fetch_pkg::addr_t       jump_target_ex_i,  // from execute
  input  fetch_pkg::addr_t       mepc_i,
  input  fetch_pkg::addr_t       depc_i,
  input  fetch_pkg::addr_t       pc_i,              // pc of the fence.i
  output fetch_pkg::addr_t       target_o
);

  fetch_pkg::addr_t exc_pc;  // trap vector address
  fetch_pkg::addr_t boot_pc;

  assign boot_pc = {boot_addr_i, 1'b0};

  ////////////////////////////////////////
  // trap vector
  ////////////////////////////////////////

  always_comb begin
    case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_EXCEPTION: begin
        exc_pc = {trap_base_addr_i, 8'h00};              // all exceptions share the base
      end
      fetch_pkg::EXC_PC_IRQ: begin
        exc_pc = {trap_base_addr_i, 1'b0, irq_id_i, 2'b00}; // one word per irq line
      end
      fetch_pkg::EXC_PC_DBD: begin
        exc_pc = {dm_halt_addr_i, 2'b00};
      end
      default: begin
        exc_pc = {trap_base_addr_i, 8'h00};
      end
    endcase
  end

  ////////////////////////////////////////
  // next pc
  ////////////////////////////////////////

  always_comb begin
    case (pc_mux_i)
      fetch_pkg::PC_BOOT: begin
        target_o = boot_pc;
      end
      fetch_pkg::PC_JUMP:      target_o = jump_target_id_i;
      fetch_pkg::PC_BRANCH:    target_o = jump_target_ex_i;
      fetch_pkg::PC_EXCEPTION: target_o = exc_pc;
      fetch_pkg::PC_MRET:      target_o = mepc_i;  // back from trap handler
      fetch_pkg::PC_DRET:      target_o = depc_i;  // leave debug mode
      fetch_pkg::PC_FENCEI: begin
        // restart right after the fence so the stream is fetched again
        target_o = pc_i + 32'd4;
      end
      default: begin
        target_o = boot_pc; // undefined select, safe fallback
      end
    endcase
  end

endmodule

//--- source/if_stage.sv
// if_stage: instruction fetch top, redirect handling and the IF/ID pipeline register

`timescale 1ns/10ps

module if_stage (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   req_i,               // core wants instructions
  input  logic                   pc_set_i,            // redirect this cycle
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  logic [30:0]            boot_addr_i,
  input  fetch_pkg::trap_base_t  trap_base_addr_i,
  input  logic [4:0]             irq_id_i,
  input  logic [29:0]            dm_halt_addr_i,
  input  fetch_pkg::addr_t       jump_target_id_i,
  input  fetch_pkg::addr_t       jump_target_ex_i,
  input  fetch_pkg::addr_t       mepc_i,
  input  fetch_pkg::addr_t       depc_i,
  input  fetch_pkg::addr_t       pc_i,

  input  logic                   halt_if_i,           // controller freezes fetch
  input  logic                   id_ready_i,          // decode can accept
  input  logic                   clear_instr_valid_i, // kill word in IF/ID

  // instruction bus
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::instr_t      instr_rdata_i,

  output logic                   instr_valid_id_o,
  output fetch_pkg::instr_t      instr_rdata_id_o,
  output fetch_pkg::addr_t       branch_target_o,
  output logic                   if_busy_o,
  output logic                   perf_imiss_o         // no word or redirect
);

  fetch_pkg::fetch_fsm_e fsm_q, fsm_n;

  fetch_pkg::addr_t  target;       // selected redirect address
  fetch_pkg::instr_t fetch_rdata;
  logic              fetch_valid;
  logic              fetch_ready;  // pop head word into IF/ID
  logic              branch_req;
  logic              valid;        // a word is offered to decode
  logic              prefetch_busy;

  ////////////////////////////////////////
  // next pc and prefetch
  ////////////////////////////////////////

  fetch_pc_select u_fetch_pc_select (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .trap_base_addr_i (trap_base_addr_i),
    .irq_id_i         (irq_id_i),
    .dm_halt_addr_i   (dm_halt_addr_i),
    .jump_target_id_i (jump_target_id_i),
    .jump_target_ex_i (jump_target_ex_i),
    .mepc_i           (mepc_i),
    .depc_i           (depc_i),
    .pc_i             (pc_i),
    .target_o         (target)
  );

  prefetch_buffer u_prefetch_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_req),
    .branch_addr_i  (target),
    .fetch_ready_i  (fetch_ready),
    .fetch_valid_o  (fetch_valid),
    .fetch_rdata_o  (fetch_rdata),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (prefetch_busy)
  );

  ////////////////////////////////////////
  // request fsm
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      fsm_q <= fetch_pkg::IDLE;
    end else begin
      fsm_q <= fsm_n;
    end
  end

  always_comb begin
    fsm_n      = fsm_q;
    branch_req = 1'b0;
    valid      = 1'b0;
    case (fsm_q)
      fetch_pkg::IDLE: begin
        if (req_i) begin
          branch_req = 1'b1;         // first fetch starts at the selected target
          fsm_n      = fetch_pkg::WAIT;
        end
      end
      fetch_pkg::WAIT: begin
        valid = fetch_valid;         // head of the fifo offered to decode
      end
      default: begin
        fsm_n = fetch_pkg::IDLE;
      end
    endcase
    // redirect beats everything, nothing handed over this cycle
    if (pc_set_i) begin
      valid      = 1'b0;
      branch_req = 1'b1;
      fsm_n      = fetch_pkg::WAIT;
    end
  end

  // pop and load happen together, only when decode is free
  assign fetch_ready = valid & id_ready_i & ~halt_if_i & req_i;

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o <= 1'b0;
    end else if (fetch_ready) begin
      instr_valid_id_o <= 1'b1;
    end else if (clear_instr_valid_i) begin
      instr_valid_id_o <= 1'b0; // a new load in the same cycle wins
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_ready) begin
      instr_rdata_id_o <= fetch_rdata; // frozen while decode stalls
    end
  end

  assign branch_target_o = target;
  assign if_busy_o       = prefetch_busy;
  assign perf_imiss_o    = ~fetch_valid | branch_req;

endmodule

//--- tests/tb_if_stage.sv
// tb_if_stage: testbench for the fetch top with a randomized in-order instruction memory

`timescale 1ns/10ps

module tb_if_stage;

  localparam int row_timeout = 400; // cycles allowed to collect one row
  localparam int long_stall  = 20;  // long enough to fill the fifo and use up credits
  localparam int clear_stall = 6;

  logic clk, rst_n, req_i, pc_set_i, halt_if_i, id_ready_i, clear_instr_valid_i;
  logic instr_gnt_i, instr_rvalid_i, instr_req_o, instr_valid_id_o, if_busy_o, perf_imiss_o;
  fetch_pkg::pc_mux_e     pc_mux_i;
  fetch_pkg::exc_pc_mux_e exc_pc_mux_i;
  logic [30:0]            boot_addr_i;
  fetch_pkg::trap_base_t  trap_base_addr_i;
  logic [4:0]             irq_id_i;
  logic [29:0]            dm_halt_addr_i;
  fetch_pkg::addr_t       jump_target_id_i, jump_target_ex_i, mepc_i, depc_i, pc_i;
  fetch_pkg::addr_t       instr_addr_o, branch_target_o;
  fetch_pkg::instr_t      instr_rdata_i, instr_rdata_id_o;

  // scenario table with one column per queue
  string                  row_name[$];
  fetch_pkg::pc_mux_e     row_mux[$];
  fetch_pkg::exc_pc_mux_e row_exc[$];
  logic [31:0]            row_op[$];    // value for the selected source input
  logic [4:0]             row_irq[$];
  fetch_pkg::addr_t       row_exp[$];   // expected redirect target
  int                     row_words[$];
  int                     row_stall[$]; // 0 none, 1 back-pressure, 2 clear while stalled

  logic [31:0] stim_rng = 32'haec753af; // operands and stall pattern
  logic [31:0] mem_rng  = 32'haec753af; // memory grant and response delays
  int          errors   = 0;
  int          checks   = 0;
  int          rows_ok  = 0;

  if_stage u_if_stage (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  function automatic logic [31:0] xorshift(inout logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    state = x;
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    return xorshift(stim_rng) & 32'hffff_fffc; // word aligned
  endfunction

  task automatic compare_bit(input string test, input string sig, input logic exp_b,
                             input logic act_b);
    checks++;
    if (act_b !== exp_b) begin
      $display("MISMATCH %s %s: expected %b actual %b", test, sig, exp_b, act_b);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // instruction memory
  ////////////////////////////////////////

  initial begin : mem_model
    fetch_pkg::addr_t pend_addr[$]; // granted and waiting for the response
    int               pend_due[$];
    int               cyc, due, last_due, gnt_wait;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    cyc            = 0;
    last_due       = 0;
    gnt_wait       = 0;
    forever begin
      @(posedge clk);
      cyc++;
      if (instr_req_o && instr_gnt_i) begin
        due = cyc + int'(xorshift(mem_rng) % 32'd3); // 1..3 cycles after the grant
        if (due <= last_due) begin
          due = last_due + 1;                 // keep answers in order
        end
        pend_addr.push_back(instr_addr_o);
        pend_due.push_back(due);
        last_due = due;
        gnt_wait = int'(xorshift(mem_rng) % 32'd3);
      end else if (instr_req_o && gnt_wait != 0) begin
        gnt_wait--;
      end
      instr_gnt_i <= (gnt_wait == 0);
      if (pend_due.size() != 0 && pend_due[0] <= cyc) begin
        void'(pend_due.pop_front());
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= ~pend_addr.pop_front(); // data is the inverted address
      end else begin
        instr_rvalid_i <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // scenario rows
  ////////////////////////////////////////

  task automatic add_row(input string name, input fetch_pkg::pc_mux_e mux,
                         input fetch_pkg::exc_pc_mux_e exc, input logic [31:0] op,
                         input logic [4:0] irq, input fetch_pkg::addr_t exp_tgt,
                         input int words, input int stall);
    row_name.push_back(name);
    row_mux.push_back(mux);
    row_exc.push_back(exc);
    row_op.push_back(op);
    row_irq.push_back(irq);
    row_exp.push_back(exp_tgt);
    row_words.push_back(words);
    row_stall.push_back(stall);
  endtask

  // unselected sources get random values so a wrong mux leg shows up
  task automatic drive_operands(input fetch_pkg::pc_mux_e mux, input logic [31:0] op);
    boot_addr_i      <= 31'(rand_word() >> 1);
    trap_base_addr_i <= 24'(rand_word() >> 8);
    dm_halt_addr_i   <= 30'(rand_word() >> 2);
    jump_target_id_i <= rand_word();
    jump_target_ex_i <= rand_word();
    mepc_i           <= rand_word();
    depc_i           <= rand_word();
    pc_i             <= rand_word();
    case (mux)
      fetch_pkg::PC_BOOT:   boot_addr_i      <= op[30:0];
      fetch_pkg::PC_JUMP:   jump_target_id_i <= op;
      fetch_pkg::PC_BRANCH: jump_target_ex_i <= op;
      fetch_pkg::PC_EXCEPTION: begin
        trap_base_addr_i <= op[23:0];
        dm_halt_addr_i   <= op[29:0];
      end
      fetch_pkg::PC_MRET:   mepc_i <= op;
      fetch_pkg::PC_DRET:   depc_i <= op;
      fetch_pkg::PC_FENCEI: pc_i   <= op;
      default: begin
      end
    endcase
  endtask

  // outputs while reset is still asserted
  task automatic check_reset_outputs();
    int err0;
    err0 = errors;
    compare_bit("reset", "instr_req_o", 1'b0, instr_req_o);
    compare_bit("reset", "instr_valid_id_o", 1'b0, instr_valid_id_o);
    compare_bit("reset", "if_busy_o", 1'b0, if_busy_o);
    compare_bit("reset", "perf_imiss_o", 1'b1, perf_imiss_o); // empty fifo has no word
    if (errors == err0) begin
      $display("reset: ok");
    end else begin
      $display("reset: failed with %0d errors", errors - err0);
    end
  endtask

  task automatic run_row(input int idx);
    fetch_pkg::addr_t  tgt;
    fetch_pkg::instr_t last, prev_rd, rd, exp_w;
    logic [31:0]       w;
    int                got, cyc, hold, err0;
    logic              vld, stall_now, stall_d1, stall_d2, win_now, win_d1, win_d2;
    logic              long_done, req_last, busy_all, imiss_d1;
    tgt  = row_exp[idx];
    err0 = errors;
    @(posedge clk);
    req_i               <= 1'b1;
    pc_set_i            <= 1'b1;
    clear_instr_valid_i <= 1'b1; // decode drops its word on the redirect
    id_ready_i          <= 1'b1;
    halt_if_i           <= 1'b0;
    pc_mux_i            <= row_mux[idx];
    exc_pc_mux_i        <= row_exc[idx];
    irq_id_i            <= row_irq[idx];
    drive_operands(row_mux[idx], row_op[idx]);
    @(posedge clk);
    checks++;
    if (branch_target_o !== tgt) begin
      $display("MISMATCH %s target: expected %h actual %h", row_name[idx], tgt, branch_target_o);
      errors++;
    end
    // a redirect cycle is a miss and keeps fetch busy
    compare_bit(row_name[idx], "perf_imiss_o on redirect", 1'b1, perf_imiss_o);
    compare_bit(row_name[idx], "if_busy_o on redirect", 1'b1, if_busy_o);
    pc_set_i            <= 1'b0;
    clear_instr_valid_i <= 1'b0;
    last      = instr_rdata_id_o; // old word that is not part of the new stream
    prev_rd   = last;
    imiss_d1  = perf_imiss_o;
    got       = 0;
    cyc       = 0;
    hold      = 0;
    stall_d1  = 1'b0;
    stall_d2  = 1'b0;
    win_d1    = 1'b0;
    win_d2    = 1'b0;
    long_done = 1'b0;
    req_last  = 1'b1;
    busy_all  = 1'b1;
    while (got < row_words[idx] && cyc < row_timeout) begin
      @(posedge clk);
      cyc++;
      rd  = instr_rdata_id_o;
      vld = instr_valid_id_o;
      // a stall driven two edges back blocked the load that would show now
      if (stall_d2 && rd !== prev_rd) begin
        $display("MISMATCH %s IF/ID word during stall: expected %h actual %h",
                 row_name[idx], prev_rd, rd);
        errors++;
      end
      if (win_d2 && row_stall[idx] == 2) begin
        compare_bit(row_name[idx], "instr_valid_id_o after clear", 1'b0, vld);
      end
      // a load at the last edge needed a fetched word and no redirect before it
      if (rd !== prev_rd) begin
        compare_bit(row_name[idx], "perf_imiss_o before a load", 1'b0, imiss_d1);
      end
      if (win_d1 && row_stall[idx] == 1) begin
        req_last = instr_req_o;          // last value is the final stalled cycle
        busy_all = busy_all & if_busy_o; // full fifo with nothing in flight drops it
      end
      if (vld && rd !== last) begin
        exp_w = ~(tgt + (32'(got) << 2));
        checks++;
        if (rd !== exp_w) begin
          $display("MISMATCH %s word %0d: expected %h actual %h", row_name[idx], got, exp_w, rd);
          errors++;
        end
        last = rd;
        got++;
      end
      prev_rd  = rd;
      imiss_d1 = perf_imiss_o;
      // decode side for the coming cycle
      stall_now = 1'b0;
      win_now   = 1'b0;
      clear_instr_valid_i <= 1'b0;
      if (!long_done && ((row_stall[idx] == 1 && got == 4) ||
                         (row_stall[idx] == 2 && got == 2))) begin
        hold      = (row_stall[idx] == 1) ? long_stall : clear_stall;
        long_done = 1'b1;
        clear_instr_valid_i <= (row_stall[idx] == 2);
      end
      if (hold > 0) begin
        hold--;
        stall_now = 1'b1;
        win_now   = 1'b1;
        id_ready_i <= 1'b0;
        halt_if_i  <= (row_stall[idx] == 1);
      end else if (row_stall[idx] == 1) begin
        w = xorshift(stim_rng);
        stall_now = w[0];
        id_ready_i <= !(w[0] && w[1]);
        halt_if_i  <= w[0] && !w[1];
      end else begin
        id_ready_i <= 1'b1;
        halt_if_i  <= 1'b0;
      end
      stall_d2 = stall_d1;
      stall_d1 = stall_now;
      win_d2   = win_d1;
      win_d1   = win_now;
    end
    if (got < row_words[idx]) begin
      $display("TIMEOUT in %s: collected %0d of %0d words in %0d cycles",
               row_name[idx], got, row_words[idx], cyc);
      errors++;
    end
    if (row_stall[idx] == 1) begin
      compare_bit(row_name[idx], "instr_req_o at the end of the long stall", 1'b0, req_last);
      if (busy_all) begin
        $display("%s: if_busy_o never went low during the long stall", row_name[idx]);
        errors++;
      end
    end
    if (errors == err0) begin
      rows_ok++;
      $display("row %0d %s: ok, %0d words", idx, row_name[idx], got);
    end else begin
      $display("row %0d %s: failed with %0d errors", idx, row_name[idx], errors - err0);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    rst_n               = 1'b0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = fetch_pkg::PC_BOOT;
    exc_pc_mux_i        = fetch_pkg::EXC_PC_EXCEPTION;
    boot_addr_i         = '0;
    trap_base_addr_i    = '0;
    irq_id_i            = '0;
    dm_halt_addr_i      = '0;
    jump_target_id_i    = '0;
    jump_target_ex_i    = '0;
    mepc_i              = '0;
    depc_i              = '0;
    pc_i                = '0;
    halt_if_i           = 1'b0;
    id_ready_i          = 1'b1;
    clear_instr_valid_i = 1'b0;
    add_row("boot", fetch_pkg::PC_BOOT, fetch_pkg::EXC_PC_EXCEPTION, 32'h40, 5'd0, 32'h80, 8, 0);
    add_row("jump", fetch_pkg::PC_JUMP, fetch_pkg::EXC_PC_EXCEPTION, 32'h1000, 5'd0,
            32'h1000, 6, 0);
    add_row("branch", fetch_pkg::PC_BRANCH, fetch_pkg::EXC_PC_EXCEPTION, 32'h2a40, 5'd0,
            32'h2a40, 6, 0);
    add_row("exception", fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_EXCEPTION, 32'h123, 5'd0,
            32'h0001_2300, 3, 0);
    add_row("irq9", fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_IRQ, 32'h123, 5'd9,
            32'h0001_2324, 3, 0);
    add_row("irq31", fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_IRQ, 32'h000a_0b0c, 5'd31,
            32'h0a0b_0c7c, 3, 0);
    add_row("debug", fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_DBD, 32'h0001_a000, 5'd3,
            32'h0006_8000, 3, 0);
    add_row("exception_hi", fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_EXCEPTION, 32'h00ff_f000,
            5'd0, 32'hfff0_0000, 2, 0);
    add_row("mret", fetch_pkg::PC_MRET, fetch_pkg::EXC_PC_EXCEPTION, 32'h5004, 5'd0,
            32'h5004, 5, 0);
    add_row("dret", fetch_pkg::PC_DRET, fetch_pkg::EXC_PC_EXCEPTION, 32'h6008, 5'd0,
            32'h6008, 5, 0);
    add_row("fencei", fetch_pkg::PC_FENCEI, fetch_pkg::EXC_PC_EXCEPTION, 32'h7000, 5'd0,
            32'h7004, 5, 0);
    add_row("backpressure", fetch_pkg::PC_JUMP, fetch_pkg::EXC_PC_EXCEPTION, 32'h8000, 5'd0,
            32'h8000, 12, 1);
    add_row("clear_valid", fetch_pkg::PC_BRANCH, fetch_pkg::EXC_PC_EXCEPTION, 32'h9000, 5'd0,
            32'h9000, 6, 2);
    repeat (5) @(posedge clk);
    check_reset_outputs();
    rst_n <= 1'b1;
    for (int i = 0; i < row_name.size(); i++) begin
      run_row(i);
    end
    $display("rows %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             row_name.size(), rows_ok, row_name.size() - rows_ok, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- if_stage.f
+incdir+include
source/fetch_pkg.sv
source/fetch_fifo.sv
source/prefetch_buffer.sv
source/fetch_pc_select.sv
source/if_stage.sv
tests/tb_if_stage.sv

//--- Makefile
# Verilator build and run of the instruction fetch testbench

VERILATOR ?= verilator
TOP       ?= tb_if_stage
FILELIST  ?= if_stage.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
